/* design/cellram_macros.svh */
// Cellular RAM macros
// Widths, stored array depth, configuration defaults, fixed latency and
// request opcodes shared by the device model, the controller and the bench

`ifndef CELLRAM_MACROS_SVH
`define CELLRAM_MACROS_SVH

// Device address and data widths
`define CELLRAM_AW 23
`define CELLRAM_DW 16

// Only the low address bits are stored, so accesses wrap at this depth
`define CELLRAM_ARRAY_AW 12

// Bus configuration register after reset, and its wait polarity bit
`define CELLRAM_DEFAULT_BCR 23'h009D1F
`define CELLRAM_WAIT_POL_BIT 10

// Wait cycles that follow the address strobe
`define CELLRAM_LATENCY 3

// Burst length field and request opcodes
`define CELLRAM_LEN_W 8
`define CELLRAM_OP_READ 2'd0
`define CELLRAM_OP_WRITE 2'd1
`define CELLRAM_OP_CONFIG 2'd2

`endif

/* design/cellram_pkg.sv */
// Cellular RAM package
// Data word type and the state encodings of the device model and the
// host-side burst controller

`default_nettype none

`include "cellram_macros.svh"

package cellram_pkg;

    // One word on the 16-bit data bus
    typedef logic [`CELLRAM_DW-1:0] word_t;

    // Device model modes, from the reference bus model
    typedef enum logic [2:0] {
        dev_idle,
        dev_configuring,
        dev_read_init,
        dev_write_init,
        dev_reading,
        dev_writing
    } dev_mode_t;

    // Controller sequence for one request
    typedef enum logic [2:0] {
        ctrl_idle,
        ctrl_address,
        ctrl_latency,
        ctrl_stream,
        ctrl_release
    } ctrl_state_t;

endpackage

`default_nettype wire

/* design/cellram_array.sv */
// Cellular RAM storage array
// Single-port memory with one write enable per byte lane and a read that
// is registered on every clock, whether or not a write takes place

`timescale 1ns/1ps
`default_nettype none

`include "cellram_macros.svh"

module cellram_array (
    input  logic                         clk,
    input  logic                         we,
    input  logic [1:0]                   be,
    input  logic [`CELLRAM_ARRAY_AW-1:0] addr,
    input  cellram_pkg::word_t           din,
    output cellram_pkg::word_t           dout
);

    localparam int depth = 1 << `CELLRAM_ARRAY_AW;
    localparam int byte_w = `CELLRAM_DW / 2;

    cellram_pkg::word_t mem [depth];

    // be[0] is the low byte (lb on the bus), be[1] the high byte (ub)
    always_ff @(posedge clk) begin
        if (we && be[0]) begin
            mem[addr][byte_w-1:0] <= din[byte_w-1:0];
        end
        if (we && be[1]) begin
            mem[addr][`CELLRAM_DW-1:byte_w] <= din[`CELLRAM_DW-1:byte_w];
        end
        // Old contents come back on a write to the same word
        dout <= mem[addr];
    end

endmodule

`default_nettype wire

/* design/cellram_device.sv */
// Cellular RAM device model
// Clocked bus model of the board's cellular RAM: a configuration register
// loaded through cre, a fixed initial latency signalled on mem_wait, and
// bursts at consecutive addresses that run until ce is released

`timescale 1ns/1ps
`default_nettype none

`include "cellram_macros.svh"

module cellram_device (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   ce,
    input  logic                   we,
    input  logic                   oe,
    input  logic                   cre,
    input  logic                   adv,
    input  logic                   lb,
    input  logic                   ub,
    input  logic [`CELLRAM_AW-1:0] addr,
    inout  wire  [`CELLRAM_DW-1:0] data,
    output logic                   mem_wait
);

    localparam logic [`CELLRAM_AW-1:0] default_bcr = `CELLRAM_DEFAULT_BCR;
    localparam int lat_w = $clog2(`CELLRAM_LATENCY + 1);
    localparam logic [lat_w-1:0] lat_last = lat_w'(`CELLRAM_LATENCY - 1);

    cellram_pkg::dev_mode_t mode;

    logic [`CELLRAM_AW-1:0]       bcr;
    logic [lat_w-1:0]             lat_cnt;
    logic                         wait_q;
    logic [`CELLRAM_ARRAY_AW-1:0] burst_addr;
    logic                         array_we;
    cellram_pkg::word_t           array_dout;

    // The array writes only in the write burst and only while selected
    assign array_we = (mode == cellram_pkg::dev_writing) && !ce;

    // Read data goes out whenever the chip is selected with oe low
    assign data = (!ce && !oe) ? array_dout : 'z;

    // wait_q is high during latency; bit 10 of the BCR picks the polarity
    assign mem_wait = bcr[`CELLRAM_WAIT_POL_BIT] ? wait_q : !wait_q;

    always_ff @(posedge clk) begin
        if (!reset) begin
            mode       <= cellram_pkg::dev_idle;
            bcr        <= default_bcr;
            lat_cnt    <= '0;
            wait_q     <= 1'b0;
            burst_addr <= '0;
        end else if (ce) begin
            // Deselecting the chip ends any access on the next edge
            mode    <= cellram_pkg::dev_idle;
            lat_cnt <= '0;
            wait_q  <= 1'b0;
        end else begin
            case (mode)
                cellram_pkg::dev_idle: begin
                    // cre wins over adv, as on the real part
                    if (cre) begin
                        mode    <= cellram_pkg::dev_configuring;
                        bcr     <= addr;
                        lat_cnt <= '0;
                        wait_q  <= 1'b1;
                    end else if (!adv) begin
                        burst_addr <= addr[`CELLRAM_ARRAY_AW-1:0];
                        lat_cnt    <= '0;
                        wait_q     <= 1'b1;
                        if (we) begin
                            mode <= cellram_pkg::dev_read_init;
                        end else begin
                            mode <= cellram_pkg::dev_write_init;
                        end
                    end
                end

                cellram_pkg::dev_configuring: begin
                    if (lat_cnt == lat_last) begin
                        mode    <= cellram_pkg::dev_idle;
                        lat_cnt <= '0;
                        wait_q  <= 1'b0;
                    end else begin
                        lat_cnt <= lat_cnt + 1'b1;
                    end
                end

                cellram_pkg::dev_read_init: begin
                    if (lat_cnt == lat_last) begin
                        mode    <= cellram_pkg::dev_reading;
                        lat_cnt <= '0;
                        wait_q  <= 1'b0;
                        // The array read is registered, so the address runs one word ahead
                        burst_addr <= burst_addr + 1'b1;
                    end else begin
                        lat_cnt <= lat_cnt + 1'b1;
                    end
                end

                cellram_pkg::dev_write_init: begin
                    if (lat_cnt == lat_last) begin
                        mode    <= cellram_pkg::dev_writing;
                        lat_cnt <= '0;
                        wait_q  <= 1'b0;
                    end else begin
                        lat_cnt <= lat_cnt + 1'b1;
                    end
                end

                // Bursts step through the array and wrap at its depth
                cellram_pkg::dev_reading: begin
                    burst_addr <= burst_addr + 1'b1;
                end

                cellram_pkg::dev_writing: begin
                    burst_addr <= burst_addr + 1'b1;
                end

                default: begin
                    mode <= cellram_pkg::dev_idle;
                end
            endcase
        end
    end

    cellram_array u_array (
        .clk  (clk),
        .we   (array_we),
        .be   ({!ub, !lb}),
        .addr (burst_addr),
        .din  (data),
        .dout (array_dout)
    );

endmodule

`default_nettype wire

/* design/cellram_burst_ctrl.sv */
// Cellular RAM burst controller
// Turns a one-cycle read, write or configure request into the clocked bus
// sequence, waits out the latency on mem_wait and streams one word per cycle.
// Write words are taken from wr_data at the edge that ends a wr_pull cycle

`timescale 1ns/1ps
`default_nettype none

`include "cellram_macros.svh"

module cellram_burst_ctrl (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      req,
    input  logic [1:0]                req_op,
    input  logic [`CELLRAM_AW-1:0]    req_addr,
    input  logic [`CELLRAM_LEN_W-1:0] req_len,
    input  logic [1:0]                req_be,
    input  cellram_pkg::word_t        wr_data,
    output logic                      wr_pull,
    output cellram_pkg::word_t        rd_data,
    output logic                      rd_valid,
    output logic                      busy,
    output logic                      done,
    output logic                      ce,
    output logic                      we,
    output logic                      oe,
    output logic                      cre,
    output logic                      adv,
    output logic                      lb,
    output logic                      ub,
    output logic [`CELLRAM_AW-1:0]    addr,
    inout  wire  [`CELLRAM_DW-1:0]    data,
    input  logic                      mem_wait
);

    localparam logic [`CELLRAM_AW-1:0] default_bcr = `CELLRAM_DEFAULT_BCR;
    localparam int lat_w = $clog2(`CELLRAM_LATENCY + 1);

    cellram_pkg::ctrl_state_t state;

    logic                      is_write;
    logic                      is_cfg;
    logic                      pol_q;
    logic [lat_w-1:0]          lat_cnt;
    logic [`CELLRAM_LEN_W-1:0] beat_left;
    logic [`CELLRAM_LEN_W-1:0] pull_left;
    cellram_pkg::word_t        wdata_q;
    logic                      wait_act;
    logic                      beat;
    logic                      pull_go;

    // Our own copy of the polarity bit tells us which level means wait
    assign wait_act = (mem_wait == pol_q);

    // A beat is one word moved on the bus, starting with the first cycle without wait
    assign beat = ((state == cellram_pkg::ctrl_latency) && !wait_act) ||
                  (state == cellram_pkg::ctrl_stream);

    // Write words are pulled ahead of the bus so that the first one is ready
    // in the cycle the device leaves its latency
    assign pull_go = is_write && (pull_left != '0) &&
                     (((state == cellram_pkg::ctrl_latency) &&
                       (int'(lat_cnt) >= `CELLRAM_LATENCY - 2)) ||
                      (state == cellram_pkg::ctrl_stream));

    assign data = (is_write && !ce && oe) ? wdata_q : 'z;

    always_ff @(posedge clk) begin
        if (wr_pull) begin
            wdata_q <= wr_data;
        end
        if (beat) begin
            rd_data <= data;
        end
    end

    always_ff @(posedge clk) begin
        if (!reset) begin
            state     <= cellram_pkg::ctrl_idle;
            ce        <= 1'b1;
            we        <= 1'b1;
            oe        <= 1'b1;
            cre       <= 1'b1;
            adv       <= 1'b1;
            lb        <= 1'b1;
            ub        <= 1'b1;
            is_write  <= 1'b0;
            is_cfg    <= 1'b0;
            pol_q     <= default_bcr[`CELLRAM_WAIT_POL_BIT];
            lat_cnt   <= '0;
            beat_left <= '0;
            pull_left <= '0;
            wr_pull   <= 1'b0;
            rd_valid  <= 1'b0;
            busy      <= 1'b0;
            done      <= 1'b0;
        end else begin
            wr_pull  <= pull_go;
            rd_valid <= beat && !is_write && !is_cfg;
            if (pull_go) begin
                pull_left <= pull_left - 1'b1;
            end

            case (state)
                cellram_pkg::ctrl_idle: begin
                    if (req) begin
                        state     <= cellram_pkg::ctrl_address;
                        busy      <= 1'b1;
                        ce        <= 1'b0;
                        adv       <= 1'b0;
                        addr      <= req_addr;
                        lat_cnt   <= '0;
                        beat_left <= req_len;
                        is_write  <= (req_op == `CELLRAM_OP_WRITE);
                        is_cfg    <= (req_op == `CELLRAM_OP_CONFIG);
                        if (req_op == `CELLRAM_OP_CONFIG) begin
                            // cre high with ce low loads addr into the BCR
                            cre       <= 1'b1;
                            we        <= 1'b1;
                            oe        <= 1'b1;
                            pol_q     <= req_addr[`CELLRAM_WAIT_POL_BIT];
                            pull_left <= '0;
                        end else if (req_op == `CELLRAM_OP_WRITE) begin
                            cre       <= 1'b0;
                            we        <= 1'b0;
                            oe        <= 1'b1;
                            lb        <= !req_be[0];
                            ub        <= !req_be[1];
                            pull_left <= req_len;
                        end else begin
                            cre       <= 1'b0;
                            we        <= 1'b1;
                            oe        <= 1'b0;
                            lb        <= !req_be[0];
                            ub        <= !req_be[1];
                            pull_left <= '0;
                        end
                    end
                end

                // adv is low for exactly one cycle
                cellram_pkg::ctrl_address: begin
                    state <= cellram_pkg::ctrl_latency;
                    adv   <= 1'b1;
                end

                cellram_pkg::ctrl_latency,
                cellram_pkg::ctrl_stream: begin
                    if (wait_act && lat_cnt != lat_w'(`CELLRAM_LATENCY)) begin
                        lat_cnt <= lat_cnt + 1'b1;
                    end
                    if (beat) begin
                        if (is_cfg || beat_left == 1) begin
                            // The last word deselects the chip and reports completion
                            state <= cellram_pkg::ctrl_release;
                            done  <= 1'b1;
                            ce    <= 1'b1;
                            we    <= 1'b1;
                            oe    <= 1'b1;
                            cre   <= 1'b1;
                            lb    <= 1'b1;
                            ub    <= 1'b1;
                        end else begin
                            state     <= cellram_pkg::ctrl_stream;
                            beat_left <= beat_left - 1'b1;
                        end
                    end
                end

                cellram_pkg::ctrl_release: begin
                    state <= cellram_pkg::ctrl_idle;
                    done  <= 1'b0;
                    busy  <= 1'b0;
                end

                default: begin
                    state <= cellram_pkg::ctrl_idle;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

/* design/cellram_subsystem.sv */
// Cellular RAM subsystem
// Host-side burst controller joined to the cellular RAM model over the
// shared control lines and the bidirectional data bus

`timescale 1ns/1ps
`default_nettype none

`include "cellram_macros.svh"

module cellram_subsystem (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      req,
    input  logic [1:0]                req_op,
    input  logic [`CELLRAM_AW-1:0]    req_addr,
    input  logic [`CELLRAM_LEN_W-1:0] req_len,
    input  logic [1:0]                req_be,
    input  cellram_pkg::word_t        wr_data,
    output logic                      wr_pull,
    output cellram_pkg::word_t        rd_data,
    output logic                      rd_valid,
    output logic                      busy,
    output logic                      done
);

    // Memory bus between the two blocks
    logic                   ce;
    logic                   we;
    logic                   oe;
    logic                   cre;
    logic                   adv;
    logic                   lb;
    logic                   ub;
    logic [`CELLRAM_AW-1:0] addr;
    logic                   mem_wait;
    wire  [`CELLRAM_DW-1:0] data;

    cellram_burst_ctrl u_ctrl (
        .clk      (clk),
        .reset    (reset),
        .req      (req),
        .req_op   (req_op),
        .req_addr (req_addr),
        .req_len  (req_len),
        .req_be   (req_be),
        .wr_data  (wr_data),
        .wr_pull  (wr_pull),
        .rd_data  (rd_data),
        .rd_valid (rd_valid),
        .busy     (busy),
        .done     (done),
        .ce       (ce),
        .we       (we),
        .oe       (oe),
        .cre      (cre),
        .adv      (adv),
        .lb       (lb),
        .ub       (ub),
        .addr     (addr),
        .data     (data),
        .mem_wait (mem_wait)
    );

    cellram_device u_device (
        .clk      (clk),
        .reset    (reset),
        .ce       (ce),
        .we       (we),
        .oe       (oe),
        .cre      (cre),
        .adv      (adv),
        .lb       (lb),
        .ub       (ub),
        .addr     (addr),
        .data     (data),
        .mem_wait (mem_wait)
    );

endmodule

`default_nettype wire

/* bench/cellram_tb.sv */
// Cellular RAM subsystem testbench
// Runs read, write and configure bursts through the host side of the
// subsystem and checks every read word against a byte-lane reference memory

`timescale 1ns/1ps
`default_nettype none

`include "cellram_macros.svh"

module cellram_tb;

    localparam int depth = 1 << `CELLRAM_ARRAY_AW;
    localparam logic [`CELLRAM_AW-1:0] bcr_default = `CELLRAM_DEFAULT_BCR;
    localparam logic [`CELLRAM_AW-1:0] bcr_wait_low =
        `CELLRAM_DEFAULT_BCR & ~(`CELLRAM_AW'(1) << `CELLRAM_WAIT_POL_BIT);

    logic                      clk;
    logic                      reset;
    logic                      req;
    logic [1:0]                req_op;
    logic [`CELLRAM_AW-1:0]    req_addr;
    logic [`CELLRAM_LEN_W-1:0] req_len;
    logic [1:0]                req_be;
    cellram_pkg::word_t        wr_data;
    logic                      wr_pull;
    cellram_pkg::word_t        rd_data;
    logic                      rd_valid;
    logic                      busy;
    logic                      done;

    // Reference words, plus which of their bytes have ever been written
    cellram_pkg::word_t ref_mem [int];
    logic [1:0]         ref_known [int];
    logic [31:0]        lcg_state;

    cellram_subsystem uut (
        .clk      (clk),
        .reset    (reset),
        .req      (req),
        .req_op   (req_op),
        .req_addr (req_addr),
        .req_len  (req_len),
        .req_be   (req_be),
        .wr_data  (wr_data),
        .wr_pull  (wr_pull),
        .rd_data  (rd_data),
        .rd_valid (rd_valid),
        .busy     (busy),
        .done     (done)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #4 clk = ~clk;
        end
    end

    task automatic fail_now();
        $display("TEST FAILED");
        $fatal(1, "Stopping at the first error");
    endtask

    // Rotated so that the weak low bits of the LCG land at the top
    function automatic logic [31:0] next_random();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return {lcg_state[15:0], lcg_state[31:16]};
    endfunction

    // Word index inside the stored array, since higher address bits are ignored
    function automatic int wrap_addr(input logic [`CELLRAM_AW-1:0] a, input int offset);
        return (int'(a) + offset) % depth;
    endfunction

    task automatic store_word(input int a, input cellram_pkg::word_t w, input logic [1:0] be);
        cellram_pkg::word_t old;
        logic [1:0]         known;
        old = ref_mem.exists(a) ? ref_mem[a] : '0;
        known = ref_known.exists(a) ? ref_known[a] : 2'b00;
        if (be[0]) begin
            old[7:0] = w[7:0];
        end
        if (be[1]) begin
            old[15:8] = w[15:8];
        end
        ref_mem[a] = old;
        ref_known[a] = known | be;
    endtask

    // Bytes never written hold unknown data and are left out of the compare
    task automatic check_read(input int a);
        cellram_pkg::word_t exp;
        cellram_pkg::word_t mask;
        logic [1:0]         known;
        exp = ref_mem.exists(a) ? ref_mem[a] : '0;
        known = ref_known.exists(a) ? ref_known[a] : 2'b00;
        mask = {{8{known[1]}}, {8{known[0]}}};
        assert ((rd_data & mask) === (exp & mask)) else begin
            $display("MISMATCH rd_data at word %h: got %h expected %h (byte mask %h)",
                     a, rd_data, exp, mask);
            fail_now();
        end
    endtask

    task automatic check_quiet(input int cycles);
        int n;
        for (n = 0; n < cycles; n++) begin
            @(negedge clk);
            assert ({busy, done, rd_valid, wr_pull} === 4'b0000) else begin
                $display("MISMATCH {busy,done,rd_valid,wr_pull}: got %h expected 0",
                         {busy, done, rd_valid, wr_pull});
                fail_now();
            end
        end
    endtask

    // One request, served until busy drops, feeding wr_pull and checking rd_valid
    task automatic run_burst(input logic [1:0] op, input logic [`CELLRAM_AW-1:0] start,
                             input int len, input logic [1:0] be);
        cellram_pkg::word_t words [$];
        logic [31:0]        r;
        int                 k;
        int                 limit;
        int                 cycles;
        int                 pulls;
        int                 beats;
        int                 dones;
        int                 exp_beats;
        int                 exp_pulls;
        limit = len + 32;
        cycles = 0;
        pulls = 0;
        beats = 0;
        dones = 0;
        exp_beats = (op == `CELLRAM_OP_READ) ? len : 0;
        exp_pulls = (op == `CELLRAM_OP_WRITE) ? len : 0;
        if (op == `CELLRAM_OP_WRITE) begin
            for (k = 0; k < len; k++) begin
                r = next_random();
                words.push_back(r[15:0]);
                store_word(wrap_addr(start, k), r[15:0], be);
            end
        end
        @(negedge clk);
        req      = 1'b1;
        req_op   = op;
        req_addr = start;
        req_len  = `CELLRAM_LEN_W'(len);
        req_be   = be;
        @(negedge clk);
        req = 1'b0;
        assert (busy === 1'b1) else begin
            $display("MISMATCH busy after req: got %h expected 1", busy);
            fail_now();
        end
        while (busy === 1'b1 && cycles < limit) begin
            if (wr_pull === 1'b1) begin
                assert (op == `CELLRAM_OP_WRITE && pulls < len) else begin
                    $display("wr_pull asked for a word that the request does not have");
                    fail_now();
                end
                wr_data = words[pulls];
                pulls++;
            end
            if (rd_valid === 1'b1) begin
                check_read(wrap_addr(start, beats));
                beats++;
            end
            if (done === 1'b1) begin
                dones++;
            end
            @(negedge clk);
            cycles++;
        end
        assert (cycles < limit) else begin
            $display("Timed out waiting for done after %0d cycles", cycles);
            fail_now();
        end
        assert (beats == exp_beats) else begin
            $display("MISMATCH rd_valid count: got %h expected %h", beats, exp_beats);
            fail_now();
        end
        assert (pulls == exp_pulls) else begin
            $display("MISMATCH wr_pull count: got %h expected %h", pulls, exp_pulls);
            fail_now();
        end
        assert (dones == 1) else begin
            $display("MISMATCH done count: got %h expected 1", dones);
            fail_now();
        end
    endtask

    // Data bursts land in a window across the top of the array so that they wrap and overlap
    task automatic random_burst();
        logic [31:0]            r;
        logic [31:0]            s;
        logic [1:0]             op;
        logic [`CELLRAM_AW-1:0] a;
        r = next_random();
        s = next_random();
        if (r[2:0] == 3'd7) begin
            op = `CELLRAM_OP_CONFIG;
        end else if (r[2]) begin
            op = `CELLRAM_OP_READ;
        end else begin
            op = `CELLRAM_OP_WRITE;
        end
        a = {s[`CELLRAM_AW-1:`CELLRAM_ARRAY_AW],
             `CELLRAM_ARRAY_AW'(depth - 16 + int'(s[4:0]))};
        if (op == `CELLRAM_OP_CONFIG) begin
            a = s[`CELLRAM_AW-1:0];
        end
        run_burst(op, a, int'(r[7:4]) + 1, r[9:8]);
    endtask

    initial begin
        int n;
        lcg_state = 32'hc188;
        reset     = 1'b0;
        req       = 1'b0;
        req_op    = `CELLRAM_OP_READ;
        req_addr  = '0;
        req_len   = '0;
        req_be    = 2'b00;
        wr_data   = '0;
        repeat (10) @(posedge clk);
        @(negedge clk);
        reset = 1'b1;

        check_quiet(6);

        run_burst(`CELLRAM_OP_WRITE, 23'h000100, 8, 2'b11);
        run_burst(`CELLRAM_OP_READ, 23'h000100, 8, 2'b11);

        // Each byte lane on its own over a full word written first
        run_burst(`CELLRAM_OP_WRITE, 23'h000200, 2, 2'b11);
        run_burst(`CELLRAM_OP_WRITE, 23'h000200, 1, 2'b01);
        run_burst(`CELLRAM_OP_WRITE, 23'h000201, 1, 2'b10);
        run_burst(`CELLRAM_OP_READ, 23'h000200, 2, 2'b11);

        // Wait active low, then back to active high
        run_burst(`CELLRAM_OP_CONFIG, bcr_wait_low, 1, 2'b00);
        run_burst(`CELLRAM_OP_WRITE, 23'h000300, 6, 2'b11);
        run_burst(`CELLRAM_OP_READ, 23'h000300, 6, 2'b11);
        run_burst(`CELLRAM_OP_CONFIG, bcr_default, 1, 2'b00);
        run_burst(`CELLRAM_OP_WRITE, 23'h000340, 5, 2'b11);
        run_burst(`CELLRAM_OP_READ, 23'h000340, 5, 2'b11);

        // Across the top of the array, then the same words through a high alias
        run_burst(`CELLRAM_OP_WRITE, `CELLRAM_AW'(depth - 3), 8, 2'b11);
        run_burst(`CELLRAM_OP_READ, `CELLRAM_AW'(depth - 3), 8, 2'b11);
        run_burst(`CELLRAM_OP_READ, 23'h100000, 5, 2'b11);

        for (n = 0; n < 20; n++) begin
            random_burst();
        end

        $display("TEST PASSED");
        $finish;
    end

endmodule

`default_nettype wire

/* list.f */
+incdir+design
design/cellram_pkg.sv
design/cellram_array.sv
design/cellram_device.sv
design/cellram_burst_ctrl.sv
design/cellram_subsystem.sv
bench/cellram_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build the cellular RAM testbench with Verilator, run it and judge the log

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -f list.f --top-module cellram_tb -o cellram_sim \
    && ./obj_dir/cellram_sim 2>&1 | tee sim.log \
    || echo "Build or simulation did not complete"

grep -qsx "TEST PASSED" sim.log \
    && { echo "Simulation passed"; exit 0; } \
    || { echo "Simulation failed"; exit 1; }
